// ==== rename_unit.f ====
source/rename_types_pkg.sv
source/rename_branch_pkg.sv
source/free_list.sv
source/checkpoint_store.sv
source/map_table.sv
source/rename_top.sv
verif/rename_assertions.sv
verif/tb_rename_top.sv

// ==== source/checkpoint_store.sv ====
//////////////////////////////////////////////////////////////////////
// Branch snapshot storage for map, allocated bitmap and free list head
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module checkpoint_store
  import rename_types_pkg::*;
  import rename_branch_pkg::*;
#(
  parameter int checkpoint_depth = checkpoint_count
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          check,
  input  cp_index_t                     check_idx,
  input  logic                          recover,
  input  cp_index_t                     recover_idx,
  input  phys_reg_t [arf_size-1:0]      snap_map,
  input  phys_mask_t                    snap_mask,
  input  fl_ptr_t                       snap_head,
  output phys_reg_t [arf_size-1:0]      restore_map,
  output phys_mask_t                    restore_mask,
  output fl_ptr_t                       restore_head,
  output logic                          restore_ok
);

  phys_reg_t [arf_size-1:0] map_slots  [checkpoint_depth];
  phys_mask_t               mask_slots [checkpoint_depth];
  fl_ptr_t                  head_slots [checkpoint_depth];
  cp_slot_state_t           slot_state [checkpoint_depth];

  // Snapshot payload
  always_ff @(posedge clock) begin
    if (check) begin
      map_slots[check_idx]  <= snap_map;
      mask_slots[check_idx] <= snap_mask;
      head_slots[check_idx] <= snap_head;
    end
  end

  // Slot occupancy; a successful recover frees the slot
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < checkpoint_depth; i++) begin
        slot_state[i] <= slot_empty;
      end
    end else begin
      if (recover && restore_ok) begin
        slot_state[recover_idx] <= slot_empty;
      end
      if (check) begin
        slot_state[check_idx] <= slot_held;
      end
    end
  end

  assign restore_map  = map_slots[recover_idx];
  assign restore_mask = mask_slots[recover_idx];
  assign restore_head = head_slots[recover_idx];
  assign restore_ok   = slot_state[recover_idx] == slot_held;

endmodule

// ==== source/free_list.sv ====
//////////////////////////////////////////////////////////////////////
// Circular free list of physical registers with multi-lane allocate
// and release; the read pointer can be restored on branch recovery
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module free_list
  import rename_types_pkg::*;
#(
  parameter int rename_width = 2
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           recover,
  input  fl_ptr_t                        restore_head,
  input  logic      [rename_width-1:0]   alloc_req,
  input  logic      [rename_width-1:0]   release_valid,
  input  phys_reg_t [rename_width-1:0]   release_reg,
  output phys_reg_t [rename_width-1:0]   alloc_reg,
  output fl_ptr_t                        head,
  output logic                           allocatable
);

  phys_reg_t entries [prf_size];

  fl_ptr_t head_q;
  fl_ptr_t tail_q;
  fl_ptr_t head_next;
  fl_ptr_t tail_next;
  fl_ptr_t free_count;

  fl_ptr_t alloc_slot   [rename_width];
  fl_ptr_t release_slot [rename_width];
  fl_ptr_t alloc_total;
  fl_ptr_t release_total;

  //////////////////////////////////////////////////////////////////////
  // Lane compaction
  //////////////////////////////////////////////////////////////////////

  // Each lane takes the slot after all requesting lanes below it
  always_comb begin
    alloc_total   = '0;
    release_total = '0;
    for (int k = 0; k < rename_width; k++) begin
      alloc_slot[k]   = head_q + alloc_total;
      release_slot[k] = tail_q + release_total;
      alloc_reg[k]    = entries[alloc_slot[k][phys_index_width-1:0]];
      alloc_total     = alloc_total + fl_ptr_t'(alloc_req[k]);
      release_total   = release_total + fl_ptr_t'(release_valid[k]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pointer update
  //////////////////////////////////////////////////////////////////////

  // Restoring the head alone rolls the count back, tail keeps releases
  always_comb begin
    if (recover) begin
      head_next = restore_head;
    end else if (!stall) begin
      head_next = head_q + alloc_total;
    end else begin
      head_next = head_q;
    end
    tail_next  = stall ? tail_q : tail_q + release_total;
    free_count = tail_next - head_next;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q      <= '0;
      tail_q      <= fl_ptr_t'(prf_size - 1);
      allocatable <= (prf_size - 1) >= rename_width;
      // Entries 0..62 hold registers 1..63
      for (int i = 0; i < prf_size; i++) begin
        entries[i] <= phys_reg_t'(i + 1);
      end
    end else begin
      head_q      <= head_next;
      tail_q      <= tail_next;
      allocatable <= free_count >= rename_width;
      if (!stall) begin
        for (int k = 0; k < rename_width; k++) begin
          if (release_valid[k]) begin
            entries[release_slot[k][phys_index_width-1:0]] <= release_reg[k];
          end
        end
      end
    end
  end

  assign head = head_q;

endmodule

// ==== source/map_table.sv ====
//////////////////////////////////////////////////////////////////////
// Integer rename map with in-group bypass, free list allocation and
// branch checkpoint recovery; wrapped by the rename top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module map_table
  import rename_types_pkg::*;
  import rename_branch_pkg::*;
#(
  parameter int rename_width     = 2,
  parameter int checkpoint_depth = checkpoint_count
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           check,
  input  logic                           recover,
  input  cp_index_t                      check_idx,
  input  cp_index_t                      recover_idx,
  input  logic      [rename_width-1:0]   check_flag,
  input  logic      [rename_width-1:0]   rd_valid,
  input  arch_reg_t [rename_width-1:0]   rs1,
  input  arch_reg_t [rename_width-1:0]   rs2,
  input  arch_reg_t [rename_width-1:0]   rd,
  input  logic      [rename_width-1:0]   release_valid,
  input  phys_reg_t [rename_width-1:0]   release_reg,
  output phys_reg_t [rename_width-1:0]   prs1,
  output phys_reg_t [rename_width-1:0]   prs2,
  output phys_reg_t [rename_width-1:0]   prd,
  output phys_reg_t [rename_width-1:0]   prev_rd,
  output logic      [rename_width-1:0]   prev_rd_valid,
  output logic                           allocatable,
  output logic                           recover_error
);

  // Committed map and allocated bitmap
  phys_reg_t [arf_size-1:0] map_q;
  phys_mask_t               mask_q;

  // Working copies walked lane by lane
  phys_reg_t [arf_size-1:0] map_work;
  phys_mask_t               mask_work;
  phys_reg_t                old_map;

  // Checkpoint traffic
  phys_reg_t [arf_size-1:0] snap_map;
  phys_reg_t [arf_size-1:0] restore_map;
  phys_mask_t               snap_mask;
  phys_mask_t               restore_mask;
  fl_ptr_t                  snap_head;
  fl_ptr_t                  restore_head;
  fl_ptr_t                  snap_offset;
  fl_ptr_t                  alloc_seen;
  logic                     restore_ok;
  logic                     restore_now;
  logic                     check_accept;

  // Free list traffic
  fl_ptr_t                           fl_head;
  logic      [rename_width-1:0]      alloc_req;
  phys_reg_t [rename_width-1:0]      alloc_reg;

  // A recover drops the rename group, even when the slot is empty
  assign alloc_req    = rd_valid & ~{rename_width{recover}};
  assign restore_now  = recover && restore_ok;
  assign check_accept = check && !stall && !recover;
  assign snap_head    = fl_head + snap_offset;

  free_list #(
    .rename_width (rename_width)
  ) i_free_list (
    .clock         (clock),
    .reset         (reset),
    .stall         (stall),
    .recover       (restore_now),
    .restore_head  (restore_head),
    .alloc_req     (alloc_req),
    .release_valid (release_valid),
    .release_reg   (release_reg),
    .alloc_reg     (alloc_reg),
    .head          (fl_head),
    .allocatable   (allocatable)
  );

  checkpoint_store #(
    .checkpoint_depth (checkpoint_depth)
  ) i_checkpoint_store (
    .clock        (clock),
    .reset        (reset),
    .check        (check_accept),
    .check_idx    (check_idx),
    .recover      (recover),
    .recover_idx  (recover_idx),
    .snap_map     (snap_map),
    .snap_mask    (snap_mask),
    .snap_head    (snap_head),
    .restore_map  (restore_map),
    .restore_mask (restore_mask),
    .restore_head (restore_head),
    .restore_ok   (restore_ok)
  );

  //////////////////////////////////////////////////////////////////////
  // Lane walk
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    map_work    = map_q;
    mask_work   = mask_q;
    snap_map    = map_q;
    snap_mask   = mask_q;
    snap_offset = '0;
    alloc_seen  = '0;
    old_map     = '0;
    for (int i = 0; i < rename_width; i++) begin
      // Sources see earlier lanes only
      prs1[i]          = map_work[rs1[i]];
      prs2[i]          = map_work[rs2[i]];
      prd[i]           = '0;
      prev_rd[i]       = '0;
      prev_rd_valid[i] = 1'b0;
      if (rd_valid[i]) begin
        old_map                 = map_work[rd[i]];
        prev_rd[i]              = old_map;
        prev_rd_valid[i]        = mask_work[old_map];
        prd[i]                  = alloc_reg[i];
        map_work[rd[i]]         = alloc_reg[i];
        mask_work[alloc_reg[i]] = 1'b1;
        alloc_seen              = alloc_seen + 1'b1;
      end
      // Snapshot after this lane
      if (check_flag[i]) begin
        snap_map    = map_work;
        snap_mask   = mask_work;
        snap_offset = alloc_seen;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      map_q         <= '0;
      mask_q        <= '0;
      recover_error <= 1'b0;
    end else begin
      recover_error <= recover && !restore_ok;
      if (recover) begin
        if (restore_ok) begin
          map_q  <= restore_map;
          mask_q <= restore_mask;
        end
      end else if (!stall) begin
        map_q  <= map_work;
        mask_q <= mask_work;
      end
    end
  end

endmodule

// ==== source/rename_branch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Branch checkpoint definitions for the rename stage
//////////////////////////////////////////////////////////////////////

package rename_branch_pkg;

  // Default number of branch checkpoints
  localparam int checkpoint_count = 4;

  localparam int cp_index_width = $clog2(checkpoint_count);

  // Checkpoint slot index as produced by decode
  typedef logic [cp_index_width-1:0] cp_index_t;

  // Whether a slot holds a valid snapshot
  typedef enum logic {
    slot_empty = 1'b0,
    slot_held  = 1'b1
  } cp_slot_state_t;

endpackage

// ==== source/rename_top.sv ====
//////////////////////////////////////////////////////////////////////
// Integer rename stage top level, sets lane and checkpoint counts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_top
  import rename_types_pkg::*;
  import rename_branch_pkg::*;
#(
  parameter int rename_width     = 2,
  parameter int checkpoint_depth = checkpoint_count
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           check,
  input  logic                           recover,
  input  cp_index_t                      check_idx,
  input  cp_index_t                      recover_idx,
  input  logic      [rename_width-1:0]   check_flag,
  input  logic      [rename_width-1:0]   rd_valid,
  input  arch_reg_t [rename_width-1:0]   rs1,
  input  arch_reg_t [rename_width-1:0]   rs2,
  input  arch_reg_t [rename_width-1:0]   rd,
  // Commit side register release
  input  logic      [rename_width-1:0]   release_valid,
  input  phys_reg_t [rename_width-1:0]   release_reg,
  output phys_reg_t [rename_width-1:0]   prs1,
  output phys_reg_t [rename_width-1:0]   prs2,
  output phys_reg_t [rename_width-1:0]   prd,
  output phys_reg_t [rename_width-1:0]   prev_rd,
  output logic      [rename_width-1:0]   prev_rd_valid,
  output logic                           allocatable,
  output logic                           recover_error
);

  map_table #(
    .rename_width     (rename_width),
    .checkpoint_depth (checkpoint_depth)
  ) i_map_table (
    .clock         (clock),
    .reset         (reset),
    .stall         (stall),
    .check         (check),
    .recover       (recover),
    .check_idx     (check_idx),
    .recover_idx   (recover_idx),
    .check_flag    (check_flag),
    .rd_valid      (rd_valid),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .release_valid (release_valid),
    .release_reg   (release_reg),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .prev_rd_valid (prev_rd_valid),
    .allocatable   (allocatable),
    .recover_error (recover_error)
  );

endmodule

// ==== source/rename_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Register file sizes and index types shared by the rename stage
//////////////////////////////////////////////////////////////////////

package rename_types_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register file sizes
  //////////////////////////////////////////////////////////////////////

  // Integer architectural registers
  localparam int arf_size = 32;

  // Integer physical registers, register 0 is the reset mapping
  localparam int prf_size = 64;

  localparam int arch_index_width = $clog2(arf_size);
  localparam int phys_index_width = $clog2(prf_size);

  //////////////////////////////////////////////////////////////////////
  // Index types
  //////////////////////////////////////////////////////////////////////

  // Architectural register index
  typedef logic [arch_index_width-1:0] arch_reg_t;

  // Physical register index
  typedef logic [phys_index_width-1:0] phys_reg_t;

  // One bit per physical register, used as the allocated bitmap
  typedef logic [prf_size-1:0] phys_mask_t;

  // Free list pointer with an extra wrap bit above the entry index
  typedef logic [phys_index_width:0] fl_ptr_t;

endpackage

// ==== verif/rename_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// Free list and stall properties bound into the rename map table
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_assertions
  import rename_types_pkg::*;
#(
  parameter int rename_width = 2
) (
  input logic                         clock,
  input logic                         reset,
  input logic                         stall,
  input logic                         recover,
  input logic      [rename_width-1:0] rd_valid,
  input logic                         allocatable,
  input phys_reg_t [arf_size-1:0]     map_q,
  input fl_ptr_t                      fl_count
);

  // Number of failed properties so far
  int failure_count = 0;

  // Register 0 is never free so at most 63
  count_in_range: assert property (@(posedge clock) disable iff (reset)
    fl_count <= fl_ptr_t'(prf_size - 1))
    else begin
      failure_count++;
      $error("free list count %0d above %0d", fl_count, prf_size - 1);
    end

  // Allocatable is registered from the same count
  alloc_low_when_short: assert property (@(posedge clock) disable iff (reset)
    (fl_count < rename_width) |-> !allocatable)
    else begin
      failure_count++;
      $error("allocatable high with %0d registers free", fl_count);
    end

  no_rename_when_short: assert property (@(posedge clock) disable iff (reset)
    (|rd_valid && !stall) |-> allocatable)
    else begin
      failure_count++;
      $error("rd_valid asserted while allocatable is low");
    end

  map_holds_in_stall: assert property (@(posedge clock) disable iff (reset)
    (stall && !recover) |=> $stable(map_q))
    else begin
      failure_count++;
      $error("map table changed during a stall");
    end

endmodule

// ==== verif/tb_rename_top.sv ====
//////////////////////////////////////////////////////////////////////
// Rename stage testbench with a reference model predicting every output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rename_top
  import rename_types_pkg::*;
  import rename_branch_pkg::*;
();

  localparam int rename_width = 2;
  // Reset and tests 1 to 5
  localparam int test_cycles    = 4 + 3 + 4 + 8 + 8 + 30;
  localparam int timeout_cycles = test_cycles + 50;

  logic clock, reset, stall, check, recover, allocatable, recover_error;
  cp_index_t check_idx, recover_idx;
  logic      [rename_width-1:0] check_flag, rd_valid, release_valid, prev_rd_valid;
  arch_reg_t [rename_width-1:0] rs1, rs2, rd;
  phys_reg_t [rename_width-1:0] release_reg, prs1, prs2, prd, prev_rd;

  // Reference model state
  phys_reg_t [arf_size-1:0]     ref_map;
  phys_reg_t [arf_size-1:0]     cp_map [checkpoint_count];
  phys_mask_t                   ref_mask;
  phys_mask_t                   cp_mask [checkpoint_count];
  phys_reg_t                    ref_pool [$];
  int                           ref_head;
  int                           cp_head [checkpoint_count];
  cp_slot_state_t               cp_state [checkpoint_count];
  phys_reg_t [rename_width-1:0] exp_prs1, exp_prs2, exp_prd, exp_prev;
  logic      [rename_width-1:0] exp_prev_valid;
  logic                         exp_alloc, exp_recover_error;

  int error_count, check_count, test_errors, test_count, cycle_count;

  rename_top #(.rename_width(rename_width)) i_dut (.*);

  bind map_table rename_assertions #(.rename_width(rename_width)) i_rename_assertions (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .recover     (recover),
    .rd_valid    (rd_valid),
    .allocatable (allocatable),
    .map_q       (map_q),
    .fl_count    (i_free_list.tail_q - i_free_list.head_q)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_phys(input string name, input phys_reg_t got, input phys_reg_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0d ns: %s got %0b, expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic check_error(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0d ns: recover_error got %0b, expected %0b", $time, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Every register maps to 0 and the free list holds 1 to 63
  function automatic void reset_model();
    ref_map  = '0;
    ref_mask = '0;
    ref_pool = {};
    for (int i = 1; i < prf_size; i++) begin
      ref_pool.push_back(phys_reg_t'(i));
    end
    ref_head = 0;
    foreach (cp_state[i]) begin
      cp_state[i] = slot_empty;
    end
    exp_alloc         = 1'b1;
    exp_recover_error = 1'b0;
  endfunction

  // Expected lane outputs for this cycle and the state after the edge
  function automatic void model_rename();
    phys_reg_t [arf_size-1:0] work_map;
    phys_reg_t [arf_size-1:0] snap_map;
    phys_mask_t               work_mask;
    phys_mask_t               snap_mask;
    int                       next_head;
    int                       snap_head;
    work_map  = ref_map;
    work_mask = ref_mask;
    next_head = ref_head;
    snap_map  = ref_map;
    snap_mask = ref_mask;
    snap_head = ref_head;
    for (int k = 0; k < rename_width; k++) begin
      exp_prs1[k]       = work_map[rs1[k]];
      exp_prs2[k]       = work_map[rs2[k]];
      exp_prd[k]        = '0;
      exp_prev[k]       = '0;
      exp_prev_valid[k] = 1'b0;
      if (rd_valid[k]) begin
        exp_prev[k]           = work_map[rd[k]];
        exp_prev_valid[k]     = work_mask[exp_prev[k]];
        exp_prd[k]            = ref_pool[next_head];
        next_head++;
        work_map[rd[k]]       = exp_prd[k];
        work_mask[exp_prd[k]] = 1'b1;
      end
      if (check_flag[k]) begin
        snap_map  = work_map;
        snap_mask = work_mask;
        snap_head = next_head;
      end
    end
    exp_recover_error = recover && cp_state[recover_idx] == slot_empty;
    if (recover && cp_state[recover_idx] == slot_held) begin
      ref_map               = cp_map[recover_idx];
      ref_mask              = cp_mask[recover_idx];
      ref_head              = cp_head[recover_idx];
      cp_state[recover_idx] = slot_empty;
    end else if (!recover && !stall) begin
      ref_map  = work_map;
      ref_mask = work_mask;
      ref_head = next_head;
      if (check) begin
        cp_map[check_idx]   = snap_map;
        cp_mask[check_idx]  = snap_mask;
        cp_head[check_idx]  = snap_head;
        cp_state[check_idx] = slot_held;
      end
    end
    // Releases land at the tail even in a recover cycle
    for (int k = 0; k < rename_width; k++) begin
      if (!stall && release_valid[k]) begin
        ref_pool.push_back(release_reg[k]);
      end
    end
    exp_alloc = (ref_pool.size() - ref_head) >= rename_width;
  endfunction

  // Outputs are stable at the falling edge
  initial begin
    forever begin
      @(negedge clock);
      if (reset !== 1'b0) begin
        reset_model();
      end else begin
        check_bit("allocatable", allocatable, exp_alloc);
        check_error(recover_error, exp_recover_error);
        model_rename();
        for (int k = 0; k < rename_width; k++) begin
          check_phys($sformatf("prs1[%0d]", k), prs1[k], exp_prs1[k]);
          check_phys($sformatf("prs2[%0d]", k), prs2[k], exp_prs2[k]);
          check_phys($sformatf("prd[%0d]", k), prd[k], exp_prd[k]);
          check_phys($sformatf("prev_rd[%0d]", k), prev_rd[k], exp_prev[k]);
          check_bit($sformatf("prev_rd_valid[%0d]", k), prev_rd_valid[k], exp_prev_valid[k]);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic clear_inputs();
    {stall, check, recover, check_idx, recover_idx} <= '0;
    {check_flag, rd_valid, release_valid} <= '0;
    {rs1, rs2, rd, release_reg} <= '0;
  endtask

  task automatic drive_group(input logic [rename_width-1:0] valid,
                             input arch_reg_t [rename_width-1:0] dst, src1, src2);
    @(posedge clock);
    clear_inputs();
    rd_valid <= valid;
    rd       <= dst;
    rs1      <= src1;
    rs2      <= src2;
  endtask

  task automatic drive_recover(input cp_index_t idx);
    @(posedge clock);
    clear_inputs();
    recover     <= 1'b1;
    recover_idx <= idx;
  endtask

  task automatic drive_release(input phys_reg_t [rename_width-1:0] regs);
    @(posedge clock);
    clear_inputs();
    release_valid <= '1;
    release_reg   <= regs;
  endtask

  task automatic end_test(input string name);
    @(posedge clock);
    clear_inputs();
    @(posedge clock);
    test_count++;
    $display("Test %0d %s: %0d errors", test_count, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  initial begin
    while (cycle_count < timeout_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    arch_reg_t [rename_width-1:0] dst;
    arch_reg_t [rename_width-1:0] src;
    logic      [31:0]             rand_word;
    int                           remaining;
    void'($urandom(32'hf2592b4d));
    reset = 1'b1;
    clear_inputs();
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    drive_group(2'b11, {5'd2, 5'd1}, {5'd3, 5'd4}, {5'd5, 5'd6});
    end_test("reset mapping and first group");

    // Lane 1 reads lane 0's rd and then both lanes write x12
    drive_group(2'b11, {5'd10, 5'd9}, {5'd9, 5'd1}, {5'd9, 5'd2});
    drive_group(2'b11, {5'd12, 5'd12}, {5'd12, 5'd9}, {5'd10, 5'd12});
    end_test("bypass within a group");

    // Stalled random group followed by the same group accepted
    repeat (3) begin
      rand_word = $urandom;
      dst = rand_word[9:0];
      src = rand_word[19:10];
      drive_group(2'b11, dst, src, ~src);
      stall <= 1'b1;
      drive_group(2'b11, dst, src, ~src);
    end
    end_test("stall");

    // Snapshot after lane 0 into slot 1
    drive_group(2'b11, {5'd21, 5'd20}, {5'd20, 5'd9}, {5'd10, 5'd12});
    check      <= 1'b1;
    check_idx  <= 2'd1;
    check_flag <= 2'b01;
    drive_group(2'b11, {5'd23, 5'd22}, {5'd21, 5'd20}, {5'd22, 5'd23});
    drive_recover(2'd1);
    drive_group(2'b11, {5'd23, 5'd22}, {5'd21, 5'd20}, {5'd22, 5'd23});
    // Slot 3 never held a snapshot
    drive_recover(2'd3);
    drive_group(2'b00, '0, {5'd21, 5'd20}, {5'd22, 5'd23});
    end_test("checkpoint and recover");

    // Drain the free list and hand four registers back
    remaining = ref_pool.size() - ref_head;
    while (remaining >= rename_width) begin
      rand_word = $urandom;
      drive_group(2'b11, rand_word[9:0], rand_word[19:10], rand_word[29:20]);
      remaining -= rename_width;
    end
    drive_release({6'd2, 6'd1});
    drive_release({6'd4, 6'd3});
    drive_group(2'b11, {5'd1, 5'd2}, '0, '0);
    drive_group(2'b11, {5'd3, 5'd4}, '0, '0);
    end_test("exhaustion and release");

    error_count += i_dut.i_map_table.i_rename_assertions.failure_count;
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
